//--- source/audio_pkg.sv
package audio_pkg;

	// audio sample and SRAM geometry
	localparam int SAMPLE_W = 16;
	localparam int ADDR_W   = 20;
	localparam int SPEED_W  = 3;

	// tick count width, up to 63
	localparam int TIME_W   = 6;

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [ADDR_W-1:0]   addr_t;

	// 0 or 1 both mean factor 1
	typedef logic [SPEED_W-1:0]  speed_t;

	typedef enum logic [2:0] {
		MODE_IDLE       = 3'd0,
		MODE_REC        = 3'd1,
		MODE_REC_PAUSE  = 3'd2,
		MODE_PLAY       = 3'd3,
		MODE_PLAY_PAUSE = 3'd4
	} rec_mode_t;

endpackage

//--- source/display_pkg.sv
package display_pkg;

	// segment order is g f e d c b a, low means lit
	typedef logic [6:0] seg_t;

	localparam seg_t SEG_DIGITS [10] = '{
		7'b1000000,
		7'b1111001,
		7'b0100100,
		7'b0110000,
		7'b0011001,
		7'b0010010,
		7'b0000010,
		7'b1111000,
		7'b0000000,
		7'b0010000
	};

endpackage

//--- source/key_debounce.sv
`timescale 1ns/1ns

module key_debounce #(
	parameter int DEBOUNCE_CYCLES = 50000
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_key_n,
	output logic o_press
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic             key_s1;
	logic             key_s2;
	logic [CNT_W-1:0] low_cnt;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			// released key idles high
			key_s1  <= 1'b1;
			key_s2  <= 1'b1;
			low_cnt <= '0;
			o_press <= 1'b0;
		end else begin
			key_s1  <= i_key_n;
			key_s2  <= key_s1;
			o_press <= 1'b0;
			if (key_s2) begin
				low_cnt <= '0;
			end else if (low_cnt != CNT_W'(DEBOUNCE_CYCLES)) begin
				low_cnt <= low_cnt + 1'b1;
				// fires once, counter then holds until release
				if (low_cnt == CNT_W'(DEBOUNCE_CYCLES - 1))
					o_press <= 1'b1;
			end
		end
	end

endmodule

//--- source/aud_capture.sv
`timescale 1ns/1ns

module aud_capture
	import audio_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_rst,
	input  logic    i_aud_bclk,
	input  logic    i_aud_lrck,
	input  logic    i_aud_adcdat,
	output sample_t o_sample,
	output logic    o_frame
);

	localparam int BIT_W = $clog2(SAMPLE_W);

	// two sync stages plus one history stage
	logic [2:0]       bclk_sr;
	logic [2:0]       lrck_sr;
	logic [1:0]       dat_sr;
	logic             bclk_rise;
	logic             lrck_fall;
	logic             busy;
	logic [BIT_W-1:0] bit_cnt;
	sample_t          shift_reg;

	assign bclk_rise = bclk_sr[1] & ~bclk_sr[2];
	assign lrck_fall = lrck_sr[2] & ~lrck_sr[1];
	assign o_sample  = shift_reg;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			bclk_sr <= '0;
			lrck_sr <= '0;
			dat_sr  <= '0;
			busy    <= 1'b0;
			bit_cnt <= '0;
			o_frame <= 1'b0;
		end else begin
			bclk_sr <= {bclk_sr[1:0], i_aud_bclk};
			lrck_sr <= {lrck_sr[1:0], i_aud_lrck};
			dat_sr  <= {dat_sr[0], i_aud_adcdat};
			o_frame <= 1'b0;
			if (lrck_fall) begin
				// left half-frame starts
				busy    <= 1'b1;
				bit_cnt <= '0;
			end else if (busy && bclk_rise) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == BIT_W'(SAMPLE_W - 1)) begin
					busy    <= 1'b0;
					o_frame <= 1'b1;
				end
			end
		end
	end

	// data path lines up with bclk_sr[1]
	always_ff @(posedge i_clk) begin
		if (busy && bclk_rise && !lrck_fall)
			shift_reg <= {shift_reg[SAMPLE_W-2:0], dat_sr[1]};
	end

endmodule

//--- source/rec_play_ctrl.sv
`timescale 1ns/1ns

module rec_play_ctrl
	import audio_pkg::*;
#(
	parameter int FRAMES_PER_TICK = 32000
) (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_rec_press,
	input  logic              i_play_press,
	input  logic              i_stop_press,
	input  logic              i_frame,
	input  sample_t           i_sample,
	input  speed_t            i_speed,
	input  logic              i_fast,
	input  logic              i_slow,
	input  sample_t           i_sram_rdata,
	output addr_t             o_sram_addr,
	output sample_t           o_sram_wdata,
	output logic              o_sram_we_n,
	output sample_t           o_dac_sample,
	output logic              o_dac_load,
	output rec_mode_t         o_mode,
	output logic [TIME_W-1:0] o_rec_time,
	output logic [TIME_W-1:0] o_play_time
);

	localparam int FRM_W = $clog2(FRAMES_PER_TICK + 1);

	addr_t            rec_addr;
	addr_t            rec_len;
	addr_t            play_addr;
	speed_t           slow_cnt;
	logic [FRM_W-1:0] rec_frm;
	logic [FRM_W-1:0] play_frm;
	logic             rd_pend;
	logic             rd_valid;
	addr_t            factor;
	addr_t            step;
	logic             slow_due;

	// speed factor and per-frame address step, fast beats slow
	assign factor   = (i_speed > speed_t'(1)) ? addr_t'(i_speed) : addr_t'(1);
	assign slow_due = (addr_t'(slow_cnt) + addr_t'(1)) >= factor;

	always_comb begin
		if (i_fast)
			step = factor;
		else if (i_slow)
			step = slow_due ? addr_t'(1) : '0;
		else
			step = addr_t'(1);
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_mode       <= MODE_IDLE;
			rec_addr     <= '0;
			rec_len      <= '0;
			play_addr    <= '0;
			slow_cnt     <= '0;
			rec_frm      <= '0;
			play_frm     <= '0;
			o_rec_time   <= '0;
			o_play_time  <= '0;
			o_sram_addr  <= '0;
			o_sram_we_n  <= 1'b1;
			rd_pend      <= 1'b0;
			rd_valid     <= 1'b0;
			o_dac_load   <= 1'b0;
			o_dac_sample <= '0;
		end else begin
			o_sram_we_n <= 1'b1;
			rd_pend     <= 1'b0;
			// read data comes back one cycle after the address
			o_dac_load  <= rd_pend;
			if (rd_pend)
				o_dac_sample <= rd_valid ? i_sram_rdata : '0;

			if (i_stop_press) begin
				o_mode <= MODE_IDLE;
			end else if (i_rec_press) begin
				case (o_mode)
					MODE_IDLE: begin
						rec_addr   <= '0;
						rec_len    <= '0;
						rec_frm    <= '0;
						o_rec_time <= '0;
						o_mode     <= MODE_REC;
					end
					MODE_REC:       o_mode <= MODE_REC_PAUSE;
					MODE_REC_PAUSE: o_mode <= MODE_REC;
					default: ;
				endcase
			end else if (i_play_press) begin
				case (o_mode)
					MODE_IDLE: begin
						play_addr   <= '0;
						slow_cnt    <= '0;
						play_frm    <= '0;
						o_play_time <= '0;
						o_mode      <= MODE_PLAY;
					end
					MODE_PLAY:       o_mode <= MODE_PLAY_PAUSE;
					MODE_PLAY_PAUSE: o_mode <= MODE_PLAY;
					default: ;
				endcase
			end

			// frame work comes last so end-of-memory stops win
			if (i_frame) begin
				rd_pend  <= 1'b1;
				rd_valid <= 1'b0;
				if (o_mode == MODE_REC) begin
					if (rec_addr == '1) begin
						o_mode <= MODE_IDLE;
					end else begin
						o_sram_addr  <= rec_addr;
						o_sram_wdata <= i_sample;
						o_sram_we_n  <= 1'b0;
						rec_addr     <= rec_addr + 1'b1;
						rec_len      <= rec_addr + 1'b1;
						if (rec_frm == FRM_W'(FRAMES_PER_TICK - 1)) begin
							rec_frm <= '0;
							if (o_rec_time != TIME_W'(59))
								o_rec_time <= o_rec_time + 1'b1;
						end else begin
							rec_frm <= rec_frm + 1'b1;
						end
					end
				end else if (o_mode == MODE_PLAY) begin
					// fast steps may overshoot the end
					if (play_addr >= rec_len) begin
						o_mode <= MODE_IDLE;
					end else begin
						o_sram_addr <= play_addr;
						rd_valid    <= 1'b1;
						play_addr   <= play_addr + step;
						if (i_slow && !i_fast)
							slow_cnt <= slow_due ? '0 : slow_cnt + 1'b1;
						else
							slow_cnt <= '0;
						if (play_frm == FRM_W'(FRAMES_PER_TICK - 1)) begin
							play_frm <= '0;
							if (o_play_time != TIME_W'(59))
								o_play_time <= o_play_time + 1'b1;
						end else begin
							play_frm <= play_frm + 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

//--- source/aud_playback.sv
`timescale 1ns/1ns

module aud_playback
	import audio_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_rst,
	input  logic    i_aud_bclk,
	input  logic    i_aud_lrck,
	input  sample_t i_dac_sample,
	input  logic    i_dac_load,
	output logic    o_aud_dacdat
);

	logic [2:0] bclk_sr;
	logic [2:0] lrck_sr;
	logic       bclk_fall;
	logic       lrck_fall;
	sample_t    pend_word;
	sample_t    shift_reg;

	assign bclk_fall    = bclk_sr[2] & ~bclk_sr[1];
	assign lrck_fall    = lrck_sr[2] & ~lrck_sr[1];
	assign o_aud_dacdat = shift_reg[SAMPLE_W-1];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			bclk_sr   <= '0;
			lrck_sr   <= '0;
			pend_word <= '0;
			shift_reg <= '0;
		end else begin
			bclk_sr <= {bclk_sr[1:0], i_aud_bclk};
			lrck_sr <= {lrck_sr[1:0], i_aud_lrck};
			// held until the next left half-frame
			if (i_dac_load)
				pend_word <= i_dac_sample;
			if (lrck_fall)
				shift_reg <= pend_word;
			else if (bclk_fall)
				// zeros fill in, so the right half stays low
				shift_reg <= {shift_reg[SAMPLE_W-2:0], 1'b0};
		end
	end

endmodule

//--- source/time_display.sv
`timescale 1ns/1ns

module time_display
	import audio_pkg::*;
	import display_pkg::*;
(
	input  logic [TIME_W-1:0] i_rec_time,
	input  logic [TIME_W-1:0] i_play_time,
	output seg_t              o_rec_tens,
	output seg_t              o_rec_ones,
	output seg_t              o_play_tens,
	output seg_t              o_play_ones
);

	// blank digit for anything past 9
	function automatic seg_t seg_of(input logic [3:0] digit);
		seg_of = (digit < 4'd10) ? SEG_DIGITS[digit] : '1;
	endfunction

	logic [TIME_W-1:0] rec_tens;
	logic [TIME_W-1:0] rec_ones;
	logic [TIME_W-1:0] play_tens;
	logic [TIME_W-1:0] play_ones;

	assign rec_tens  = i_rec_time / TIME_W'(10);
	assign rec_ones  = i_rec_time % TIME_W'(10);
	assign play_tens = i_play_time / TIME_W'(10);
	assign play_ones = i_play_time % TIME_W'(10);

	assign o_rec_tens  = seg_of(rec_tens[3:0]);
	assign o_rec_ones  = seg_of(rec_ones[3:0]);
	assign o_play_tens = seg_of(play_tens[3:0]);
	assign o_play_ones = seg_of(play_ones[3:0]);

endmodule

//--- source/audio_rec_top.sv
`timescale 1ns/1ns

module audio_rec_top
	import audio_pkg::*;
	import display_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 50000,
	parameter int FRAMES_PER_TICK = 32000
) (
	input  logic      i_clk,
	input  logic      i_rst,
	// bit 0 record/pause, bit 1 play/pause, bit 2 stop
	input  logic [2:0] i_key_n,
	input  speed_t    i_speed,
	input  logic      i_fast,
	input  logic      i_slow,
	input  logic      i_aud_bclk,
	input  logic      i_aud_lrck,
	input  logic      i_aud_adcdat,
	output logic      o_aud_dacdat,
	output addr_t     o_sram_addr,
	output sample_t   o_sram_wdata,
	output logic      o_sram_we_n,
	input  sample_t   i_sram_rdata,
	output rec_mode_t o_mode,
	output seg_t      o_rec_tens,
	output seg_t      o_rec_ones,
	output seg_t      o_play_tens,
	output seg_t      o_play_ones
);

	logic [2:0]        press;
	sample_t           adc_sample;
	logic              frame;
	sample_t           dac_sample;
	logic              dac_load;
	logic [TIME_W-1:0] rec_time;
	logic [TIME_W-1:0] play_time;

	for (genvar k = 0; k < 3; k++) begin : g_key
		key_debounce #(
			.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
		) i_key_debounce (
			.i_clk  (i_clk),
			.i_rst  (i_rst),
			.i_key_n(i_key_n[k]),
			.o_press(press[k])
		);
	end

	aud_capture i_aud_capture (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_aud_bclk  (i_aud_bclk),
		.i_aud_lrck  (i_aud_lrck),
		.i_aud_adcdat(i_aud_adcdat),
		.o_sample    (adc_sample),
		.o_frame     (frame)
	);

	rec_play_ctrl #(
		.FRAMES_PER_TICK(FRAMES_PER_TICK)
	) i_rec_play_ctrl (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_rec_press (press[0]),
		.i_play_press(press[1]),
		.i_stop_press(press[2]),
		.i_frame     (frame),
		.i_sample    (adc_sample),
		.i_speed     (i_speed),
		.i_fast      (i_fast),
		.i_slow      (i_slow),
		.i_sram_rdata(i_sram_rdata),
		.o_sram_addr (o_sram_addr),
		.o_sram_wdata(o_sram_wdata),
		.o_sram_we_n (o_sram_we_n),
		.o_dac_sample(dac_sample),
		.o_dac_load  (dac_load),
		.o_mode      (o_mode),
		.o_rec_time  (rec_time),
		.o_play_time (play_time)
	);

	aud_playback i_aud_playback (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_aud_bclk  (i_aud_bclk),
		.i_aud_lrck  (i_aud_lrck),
		.i_dac_sample(dac_sample),
		.i_dac_load  (dac_load),
		.o_aud_dacdat(o_aud_dacdat)
	);

	time_display i_time_display (
		.i_rec_time (rec_time),
		.i_play_time(play_time),
		.o_rec_tens (o_rec_tens),
		.o_rec_ones (o_rec_ones),
		.o_play_tens(o_play_tens),
		.o_play_ones(o_play_ones)
	);

endmodule

//--- verif/tb_audio_rec.sv
`timescale 1ns/1ns

module tb_audio_rec
	import audio_pkg::*;
	import display_pkg::*;
();

	localparam int DEB_CYCLES   = 8;
	localparam int FRM_PER_TICK = 4;
	localparam int HOLD_CYCLES  = DEB_CYCLES + 4;
	localparam int FRAME_CYC    = 256;
	localparam int HALF_CYC     = FRAME_CYC / 2;
	localparam int SLOW_FRAMES  = 10;
	// frames spent in each test with reset counted in the first
	localparam int TEST_FRAMES  = 4 + 13 + 12 + 10 + 7 + 13;
	localparam int CYCLE_LIMIT  = TEST_FRAMES * FRAME_CYC * 3 / 2;
	localparam int KEY_REC      = 0;
	localparam int KEY_PLAY     = 1;
	localparam int KEY_STOP     = 2;

	// one bit per segment, a in bit 0 up to g in bit 6
	localparam logic [6:0] SEG_A = 7'b0000001;
	localparam logic [6:0] SEG_B = 7'b0000010;
	localparam logic [6:0] SEG_C = 7'b0000100;
	localparam logic [6:0] SEG_D = 7'b0001000;
	localparam logic [6:0] SEG_E = 7'b0010000;
	localparam logic [6:0] SEG_F = 7'b0100000;
	localparam logic [6:0] SEG_G = 7'b1000000;

	logic       clk = 1'b0;
	logic       i_rst;
	logic [2:0] i_key_n;
	speed_t     i_speed;
	logic       i_fast;
	logic       i_slow;
	logic       i_aud_bclk;
	logic       i_aud_lrck;
	logic       i_aud_adcdat;
	logic       o_aud_dacdat;
	addr_t      o_sram_addr;
	sample_t    o_sram_wdata;
	logic       o_sram_we_n;
	sample_t    i_sram_rdata;
	rec_mode_t  o_mode;
	seg_t       o_rec_tens;
	seg_t       o_rec_ones;
	seg_t       o_play_tens;
	seg_t       o_play_ones;

	sample_t mem [0:(1 << ADDR_W) - 1];
	sample_t tx_q[$];
	sample_t rx_q[$];
	sample_t rec_exp[$];
	sample_t play_exp[$];
	sample_t rx_word;
	int      ph = FRAME_CYC - 1;
	int      frame_no = -1;
	int      cycles = 0;
	integer  seed;
	event    frame_start;

	audio_rec_top #(
		.DEBOUNCE_CYCLES(DEB_CYCLES),
		.FRAMES_PER_TICK(FRM_PER_TICK)
	) i_audio_rec_top (
		.i_clk       (clk),
		.i_rst       (i_rst),
		.i_key_n     (i_key_n),
		.i_speed     (i_speed),
		.i_fast      (i_fast),
		.i_slow      (i_slow),
		.i_aud_bclk  (i_aud_bclk),
		.i_aud_lrck  (i_aud_lrck),
		.i_aud_adcdat(i_aud_adcdat),
		.o_aud_dacdat(o_aud_dacdat),
		.o_sram_addr (o_sram_addr),
		.o_sram_wdata(o_sram_wdata),
		.o_sram_we_n (o_sram_we_n),
		.i_sram_rdata(i_sram_rdata),
		.o_mode      (o_mode),
		.o_rec_tens  (o_rec_tens),
		.o_rec_ones  (o_rec_ones),
		.o_play_tens (o_play_tens),
		.o_play_ones (o_play_ones)
	);

	always #2 clk = ~clk;

	// async SRAM model with combinational read
	always @(posedge clk) begin
		if (!o_sram_we_n)
			mem[o_sram_addr] <= o_sram_wdata;
	end
	assign i_sram_rdata = mem[o_sram_addr];

	// codec model with an 8-cycle bit clock and 32 bits per frame
	always @(negedge clk) begin
		if (ph == FRAME_CYC - 1) begin
			ph = 0;
			frame_no++;
		end else begin
			ph++;
		end
		// DAC bit read in the middle of each left-half bit
		if (ph < HALF_CYC && ph % 8 == 4) begin
			rx_word = {rx_word[SAMPLE_W-2:0], o_aud_dacdat};
			if (ph == HALF_CYC - 4)
				rx_q.push_back(rx_word);
		end
		i_aud_bclk   = (ph % 8) >= 4;
		i_aud_lrck   = ph >= HALF_CYC;
		i_aud_adcdat = (ph < HALF_CYC) ? tx_q[frame_no][SAMPLE_W - 1 - ph / 8] : 1'b0;
		if (ph == 0)
			-> frame_start;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// active-low pattern built from the lit segments
	function automatic seg_t digit_segments(input int d);
		logic [6:0] lit;
		case (d)
			0: lit = SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F;
			1: lit = SEG_B | SEG_C;
			2: lit = SEG_A | SEG_B | SEG_D | SEG_E | SEG_G;
			3: lit = SEG_A | SEG_B | SEG_C | SEG_D | SEG_G;
			4: lit = SEG_B | SEG_C | SEG_F | SEG_G;
			5: lit = SEG_A | SEG_C | SEG_D | SEG_F | SEG_G;
			6: lit = SEG_A | SEG_C | SEG_D | SEG_E | SEG_F | SEG_G;
			7: lit = SEG_A | SEG_B | SEG_C;
			8: lit = SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F | SEG_G;
			9: lit = SEG_A | SEG_B | SEG_C | SEG_D | SEG_F | SEG_G;
			default: lit = '0;
		endcase
		return ~lit;
	endfunction

	task automatic press_key(input int key, input int len);
		i_key_n[key] = 1'b0;
		repeat (len) @(negedge clk);
		i_key_n[key] = 1'b1;
	endtask

	task automatic start_at_frame(input int key);
		@(frame_start);
		rx_q.delete();
		press_key(key, HOLD_CYCLES);
	endtask

	// logs the sample sent in each recorded frame
	task automatic log_frames(input int n);
		repeat (n) begin
			rec_exp.push_back(tx_q[frame_no]);
			@(frame_start);
		end
	endtask

	task automatic wait_idle();
		while (o_mode != MODE_IDLE)
			@(negedge clk);
	endtask

	task automatic check_sram();
		for (int i = 0; i < rec_exp.size(); i++)
			check($sformatf("sram word %0d", i), rec_exp[i], mem[i]);
	endtask

	task automatic check_received();
		int n;
		while (rx_q.size() > 0 && rx_q[0] == '0)
			void'(rx_q.pop_front());
		n = play_exp.size();
		if (rx_q.size() <= n) begin
			$display("Error: only %0d DAC words received, %0d expected",
				rx_q.size(), n + 1);
			$display("Simulation failed");
			$fatal(1);
		end
		for (int i = 0; i < n; i++)
			check($sformatf("dac word %0d", i), play_exp[i], rx_q[i]);
		// DAC goes quiet once playback is over
		check("dac word after end", 0, rx_q[n]);
	endtask

	task automatic debounce_rec_key();
		@(frame_start);
		// too short to count as a press
		press_key(KEY_REC, 5);
		repeat (DEB_CYCLES + 8) @(negedge clk);
		check("o_mode", MODE_IDLE, o_mode);
		start_at_frame(KEY_REC);
		check("o_mode", MODE_REC, o_mode);
		start_at_frame(KEY_STOP);
		check("o_mode", MODE_IDLE, o_mode);
	endtask

	task automatic record_and_stop();
		rec_exp.delete();
		start_at_frame(KEY_REC);
		log_frames(12);
		press_key(KEY_STOP, HOLD_CYCLES);
		check("o_mode", MODE_IDLE, o_mode);
		check_sram();
		check("o_rec_tens", digit_segments(0), o_rec_tens);
		check("o_rec_ones", digit_segments(12 / FRM_PER_TICK), o_rec_ones);
	endtask

	task automatic pause_and_resume();
		rec_exp.delete();
		start_at_frame(KEY_REC);
		log_frames(3);
		press_key(KEY_REC, HOLD_CYCLES);
		check("o_mode", MODE_REC_PAUSE, o_mode);
		// these four frames stay out of the SRAM
		repeat (4) @(frame_start);
		press_key(KEY_REC, HOLD_CYCLES);
		check("o_mode", MODE_REC, o_mode);
		log_frames(4);
		press_key(KEY_STOP, HOLD_CYCLES);
		check("o_mode", MODE_IDLE, o_mode);
		check_sram();
	endtask

	task automatic play_normal();
		play_exp = rec_exp;
		start_at_frame(KEY_PLAY);
		check("o_mode", MODE_PLAY, o_mode);
		wait_idle();
		repeat (2) @(frame_start);
		check_received();
	endtask

	task automatic play_fast_slow();
		i_fast  = 1'b1;
		i_speed = 3'd2;
		play_exp.delete();
		for (int i = 0; i < rec_exp.size(); i += 2)
			play_exp.push_back(rec_exp[i]);
		start_at_frame(KEY_PLAY);
		wait_idle();
		repeat (2) @(frame_start);
		check_received();

		i_fast = 1'b0;
		i_slow = 1'b1;
		play_exp.delete();
		for (int i = 0; i < SLOW_FRAMES; i++)
			play_exp.push_back(rec_exp[i / 2]);
		start_at_frame(KEY_PLAY);
		repeat (SLOW_FRAMES) @(frame_start);
		press_key(KEY_STOP, HOLD_CYCLES);
		check("o_mode", MODE_IDLE, o_mode);
		check("o_play_tens", digit_segments(0), o_play_tens);
		check("o_play_ones", digit_segments(SLOW_FRAMES / FRM_PER_TICK), o_play_ones);
		repeat (2) @(frame_start);
		check_received();
		i_slow = 1'b0;
	endtask

	initial begin
		sample_t w;
		i_rst        = 1'b1;
		i_key_n      = 3'b111;
		i_speed      = '0;
		i_fast       = 1'b0;
		i_slow       = 1'b0;
		i_aud_bclk   = 1'b0;
		i_aud_lrck   = 1'b0;
		i_aud_adcdat = 1'b0;
		seed         = 53;
		for (int a = 0; a < (1 << ADDR_W); a++)
			mem[a] = sample_t'(a) ^ sample_t'(a >> 4);
		// one nonzero sample per codec frame
		while (tx_q.size() < 128) begin
			w = sample_t'($random(seed));
			if (w != '0)
				tx_q.push_back(w);
		end
		repeat (8) @(negedge clk);
		i_rst = 1'b0;

		debounce_rec_key();
		record_and_stop();
		pause_and_resume();
		play_normal();
		play_fast_slow();

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- sources.f
source/audio_pkg.sv
source/display_pkg.sv
source/key_debounce.sv
source/aud_capture.sv
source/rec_play_ctrl.sv
source/aud_playback.sv
source/time_display.sv
source/audio_rec_top.sv
verif/tb_audio_rec.sv
